// ==== Makefile ====
# Verilator build and run for the multi-lane MAC engine

VERILATOR ?= verilator
TOP       ?= mac_array_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test failures found

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== rtl/mac_arith_pkg.sv ====
// ------------------------------------------------
// arithmetic definitions for the MAC datapath
// operand, product and result words, the shift
// applied to the addend and the add/sub encoding
// ------------------------------------------------

package mac_arith_pkg;

    // operand and product widths
    localparam int OPND_W = 56;
    localparam int PROD_W = 2 * OPND_W;

    // result keeps the low bits of (a << ACC_SHIFT) +/- b*c
    localparam int RES_W     = 110;
    localparam int ACC_SHIFT = 54;

    // one signed operand
    typedef logic signed [OPND_W-1:0] operand_t;

    // full signed product of two operands
    typedef logic signed [PROD_W-1:0] product_t;

    // multiply-accumulate result word
    typedef logic signed [RES_W-1:0] result_t;

    // op bit
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } op_e;

endpackage

// ==== rtl/mac_array_pkg.sv ====
// ------------------------------------------------
// array configuration for the MAC engine
// lane count and multiplier depth
// ------------------------------------------------

package mac_array_pkg;

    // lanes fed in rotation
    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;

    // multiplier pipeline depth used by each lane, 1 to 4
    localparam int MUL_STAGES = 2;

endpackage

// ==== rtl/mac_array_top.sv ====
// ------------------------------------------------
// multi-lane multiply-accumulate engine
// dispatcher, rotating lanes and in-order collector
// ------------------------------------------------
`timescale 1ns/1ps

module mac_array_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid_i,
    output logic                    in_ready_o,
    input  mac_arith_pkg::operand_t in_a_i,
    input  mac_arith_pkg::operand_t in_b_i,
    input  mac_arith_pkg::operand_t in_c_i,
    input  mac_arith_pkg::op_e      in_op_i,
    output logic                    out_valid_o,
    input  logic                    out_ready_i,
    output mac_arith_pkg::result_t  out_d_o
);

    logic [mac_array_pkg::NUM_LANES-1:0] lane_valid, lane_ready;
    logic [mac_array_pkg::NUM_LANES-1:0] res_valid, res_ready;
    mac_arith_pkg::result_t              res_d [mac_array_pkg::NUM_LANES];

    mac_dispatch u_dispatch (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .lane_ready_i (lane_ready),
        .lane_valid_o (lane_valid)
    );

    // operands are shared, only the pointed lane sees valid
    for (genvar i = 0; i < mac_array_pkg::NUM_LANES; i++) begin : g_lane
        mac_lane u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .valid_i     (lane_valid[i]),
            .ready_o     (lane_ready[i]),
            .a_i         (in_a_i),
            .b_i         (in_b_i),
            .c_i         (in_c_i),
            .op_i        (in_op_i),
            .res_valid_o (res_valid[i]),
            .res_ready_i (res_ready[i]),
            .res_d_o     (res_d[i])
        );
    end

    mac_collect u_collect (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_valid_i (res_valid),
        .res_d_i     (res_d),
        .res_ready_o (res_ready),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_d_o     (out_d_o)
    );

endmodule

// ==== rtl/mac_collect.sv ====
// ------------------------------------------------
// result collector
// drains lanes in the dispatch rotation so results
// leave in entry order, one-entry output register
// ------------------------------------------------
`timescale 1ns/1ps

module mac_collect (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic [mac_array_pkg::NUM_LANES-1:0] res_valid_i,
    input  mac_arith_pkg::result_t              res_d_i [mac_array_pkg::NUM_LANES],
    output logic [mac_array_pkg::NUM_LANES-1:0] res_ready_o,
    output logic                                out_valid_o,
    input  logic                                out_ready_i,
    output mac_arith_pkg::result_t              out_d_o
);

    logic [mac_array_pkg::LANE_IDX_W-1:0] ptr_q;
    logic                                 out_valid_q;
    mac_arith_pkg::result_t               out_d_q;
    logic                                 can_load;
    logic                                 take;

    // room when empty or draining this cycle
    assign can_load = !out_valid_q || out_ready_i;
    assign take     = res_valid_i[ptr_q] && can_load;

    always_comb begin
        res_ready_o        = '0;
        res_ready_o[ptr_q] = can_load;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q       <= '0;
            out_valid_q <= 1'b0;
        end else if (take) begin
            out_valid_q <= 1'b1;
            if (ptr_q == mac_array_pkg::LANE_IDX_W'(mac_array_pkg::NUM_LANES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            out_d_q <= res_d_i[ptr_q];
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_d_o     = out_d_q;

    a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_d_o));

endmodule

// ==== rtl/mac_dispatch.sv ====
// ------------------------------------------------
// operation dispatcher
// hands each accepted operation to the next lane
// in strict rotation
// ------------------------------------------------
`timescale 1ns/1ps

module mac_dispatch (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid_i,
    output logic                                in_ready_o,
    input  logic [mac_array_pkg::NUM_LANES-1:0] lane_ready_i,
    output logic [mac_array_pkg::NUM_LANES-1:0] lane_valid_o
);

    logic [mac_array_pkg::LANE_IDX_W-1:0] ptr_q;
    logic                                 accept;

    // stall when the pointed lane is still busy
    assign in_ready_o = lane_ready_i[ptr_q];
    assign accept     = in_valid_i && in_ready_o;

    always_comb begin
        lane_valid_o        = '0;
        lane_valid_o[ptr_q] = in_valid_i;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr_q <= '0;
        end else if (accept) begin
            if (ptr_q == mac_array_pkg::LANE_IDX_W'(mac_array_pkg::NUM_LANES - 1)) begin
                ptr_q <= '0;
            end else begin
                ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // the lane that took the operation goes busy
    a_lane_taken: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> !lane_ready_i[$past(ptr_q)]);

endmodule

// ==== rtl/mac_lane.sv ====
// ------------------------------------------------
// single multiply-accumulate lane
// computes (a << 54) +/- b*c, skips the add when
// a is zero and holds the result until taken
// ------------------------------------------------
`timescale 1ns/1ps

module mac_lane (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_i,
    output logic                    ready_o,
    input  mac_arith_pkg::operand_t a_i,
    input  mac_arith_pkg::operand_t b_i,
    input  mac_arith_pkg::operand_t c_i,
    input  mac_arith_pkg::op_e      op_i,
    output logic                    res_valid_o,
    input  logic                    res_ready_i,
    output mac_arith_pkg::result_t  res_d_o
);

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        ADD,
        HOLD
    } state_e;

    state_e                  state_q, state_d;
    mac_arith_pkg::operand_t a_q;
    mac_arith_pkg::op_e      op_q;
    logic                    a_zero;
    logic                    mul_start, mul_valid;
    mac_arith_pkg::product_t mul_prod;
    mac_arith_pkg::result_t  term, sum, res_q;

    assign ready_o     = (state_q == IDLE);
    assign mul_start   = valid_i && ready_o;
    assign res_valid_o = (state_q == HOLD);
    assign res_d_o     = res_q;
    assign a_zero      = (a_q == '0);

    mul_pipe #(
        .STAGES (mac_array_pkg::MUL_STAGES)
    ) u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (mul_start),
        .a_i      (b_i),
        .b_i      (c_i),
        .valid_o  (mul_valid),
        .result_o (mul_prod)
    );

    // product or its negation, then the shifted addend
    assign term = (op_q == mac_arith_pkg::OP_SUB) ?
                  -mac_arith_pkg::result_t'(mul_prod[mac_arith_pkg::RES_W-1:0]) :
                  mac_arith_pkg::result_t'(mul_prod[mac_arith_pkg::RES_W-1:0]);
    assign sum  = (mac_arith_pkg::result_t'(a_q) <<< mac_arith_pkg::ACC_SHIFT) + term;

    always_ff @(posedge clk) begin
        if (mul_start) begin
            a_q  <= a_i;
            op_q <= op_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (valid_i) state_d = MUL;
            MUL:  if (mul_valid) state_d = a_zero ? HOLD : ADD;
            ADD:  state_d = HOLD;
            HOLD: if (res_ready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    // zero addend loads straight from the multiplier
    always_ff @(posedge clk) begin
        if (state_q == MUL && mul_valid && a_zero) begin
            res_q <= term;
        end else if (state_q == ADD) begin
            res_q <= sum;
        end
    end

    a_busy_after_accept: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |=> !ready_o [*mac_array_pkg::MUL_STAGES+1]);

    a_res_held: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_d_o));

endmodule

// ==== rtl/mul_pipe.sv ====
// ------------------------------------------------
// pipelined signed multiplier
// product emerges STAGES cycles after start
// ------------------------------------------------
`timescale 1ns/1ps

module mul_pipe #(
    parameter int STAGES = mac_array_pkg::MUL_STAGES
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start_i,
    input  mac_arith_pkg::operand_t a_i,
    input  mac_arith_pkg::operand_t b_i,
    output logic                    valid_o,
    output mac_arith_pkg::product_t result_o
);

    mac_arith_pkg::product_t prod;
    mac_arith_pkg::product_t data_q [STAGES];
    logic [STAGES-1:0]       vld_q;

    assign prod = mac_arith_pkg::product_t'(a_i) * mac_arith_pkg::product_t'(b_i);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= start_i;
            for (int s = 1; s < STAGES; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    // data only moves with its valid, so the last stage holds until the next start
    always_ff @(posedge clk) begin
        if (start_i) begin
            data_q[0] <= prod;
        end
        for (int s = 1; s < STAGES; s++) begin
            if (vld_q[s-1]) begin
                data_q[s] <= data_q[s-1];
            end
        end
    end

    assign valid_o  = vld_q[STAGES-1];
    assign result_o = data_q[STAGES-1];

    // product leaves together with the valid that started it
    a_prod_follows_valid: assert property (@(posedge clk) disable iff (!rst_n)
        valid_o |-> result_o == $past(prod, STAGES));

endmodule

// ==== sources.f ====
rtl/mac_arith_pkg.sv
rtl/mac_array_pkg.sv
rtl/mul_pipe.sv
rtl/mac_lane.sv
rtl/mac_dispatch.sv
rtl/mac_collect.sv
rtl/mac_array_top.sv
tb/mac_array_tb.sv

// ==== tb/mac_array_tb.sv ====
// --------------------------------------------------
// testbench for the multi-lane MAC engine
// file-driven operations, random output stalls and
// in-order result checking
// --------------------------------------------------
`timescale 1ns/1ps

module mac_array_tb;

    localparam int N_OPS      = 22;
    localparam int N_COLS     = 5;
    localparam int N_PASSES   = 2;
    localparam int MAX_CYCLES = N_PASSES * N_OPS * 20 + 100;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid_i;
    logic                    in_ready_o;
    mac_arith_pkg::operand_t in_a_i;
    mac_arith_pkg::operand_t in_b_i;
    mac_arith_pkg::operand_t in_c_i;
    mac_arith_pkg::op_e      in_op_i;
    logic                    out_valid_o;
    logic                    out_ready_i;
    mac_arith_pkg::result_t  out_d_o;

    // a, b, c, op and expected result per operation
    logic [111:0]           stim_mem [N_OPS*N_COLS];
    mac_arith_pkg::result_t exp_q [$];
    logic [15:0]            lfsr;
    int                     pass_cnt;
    int                     fail_cnt;
    int                     cycle_cnt;

    mac_array_top uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_a_i      (in_a_i),
        .in_b_i      (in_b_i),
        .in_c_i      (in_c_i),
        .in_op_i     (in_op_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_d_o     (out_d_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Test failures found");
        $finish;
    end

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic check_result(input string name, input mac_arith_pkg::result_t exp_v,
                                input mac_arith_pkg::result_t act_v);
        if (act_v !== exp_v) begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, exp_v, act_v);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("Fail at %0t: %s expected %b, got %b", $time, name, exp_v, act_v);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_group(input string name, input int fails_before);
        if (fail_cnt == fails_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d failed checks", name, fail_cnt - fails_before);
        end
    endtask

    // every entry back to back, each output transfer checked against the queue
    task automatic run_stream(input string name, input logic random_ready);
        int                     idx;
        int                     got;
        int                     fails_before;
        logic                   held;
        mac_arith_pkg::result_t held_d;
        idx          = 0;
        got          = 0;
        held         = 1'b0;
        held_d       = '0;
        fails_before = fail_cnt;
        while (got < N_OPS) begin
            @(negedge clk);
            if (idx < N_OPS) begin
                in_a_i     = stim_mem[idx*N_COLS][mac_arith_pkg::OPND_W-1:0];
                in_b_i     = stim_mem[idx*N_COLS+1][mac_arith_pkg::OPND_W-1:0];
                in_c_i     = stim_mem[idx*N_COLS+2][mac_arith_pkg::OPND_W-1:0];
                in_op_i    = mac_arith_pkg::op_e'(stim_mem[idx*N_COLS+3][0]);
                in_valid_i = 1'b1;
                // in_ready_o comes from lane state only, so it holds until the edge
                if (in_ready_o) begin
                    exp_q.push_back(stim_mem[idx*N_COLS+4][mac_arith_pkg::RES_W-1:0]);
                    idx++;
                end
            end else begin
                in_valid_i = 1'b0;
            end
            if (random_ready) begin
                lfsr        = lfsr_next(lfsr);
                out_ready_i = lfsr[0];
            end else begin
                out_ready_i = 1'b1;
            end
            // a stalled word must not move
            if (held) begin
                check_flag("out_valid_o", 1'b1, out_valid_o);
                check_result("out_d_o", held_d, out_d_o);
            end
            held   = out_valid_o && !out_ready_i;
            held_d = out_d_o;
            if (out_valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Output at %0t with no operation outstanding", $time);
                    fail_cnt++;
                end else begin
                    check_result("out_d_o", exp_q.pop_front(), out_d_o);
                end
                got++;
            end
        end
        report_group(name, fails_before);
    endtask

    initial begin
        int fails_before;
        rst_n       = 1'b0;
        in_valid_i  = 1'b0;
        in_a_i      = '0;
        in_b_i      = '0;
        in_c_i      = '0;
        in_op_i     = mac_arith_pkg::OP_ADD;
        out_ready_i = 1'b1;
        lfsr        = 16'd66;
        pass_cnt    = 0;
        fail_cnt    = 0;
        $readmemh("tb/mac_stimulus.txt", stim_mem);
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fails_before = fail_cnt;
        @(negedge clk);
        check_flag("in_ready_o", 1'b1, in_ready_o);
        check_flag("out_valid_o", 1'b0, out_valid_o);
        report_group("reset state", fails_before);

        run_stream("ordered burst, output always ready", 1'b0);
        run_stream("burst under random output stalls", 1'b1);

        // nothing may follow the last expected word
        fails_before = fail_cnt;
        repeat (10) begin
            @(negedge clk);
            out_ready_i = 1'b1;
            check_flag("out_valid_o", 1'b0, out_valid_o);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected results were never delivered", exp_q.size());
            fail_cnt++;
        end
        report_group("drain", fails_before);

        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== tb/mac_stimulus.txt ====
// columns: a, b, c (56-bit hex), op (0 add, 1 sub), expected result (110-bit hex)
// result = (a << 54) + b*c or (a << 54) - b*c, low 110 bits kept
00000000000001 00000000000002 00000000000003 0 0000000000000040000000000006
00000000000000 00000000000007 00000000000009 0 000000000000000000000000003F
00000000000001 00000000000002 00000000000003 1 000000000000003FFFFFFFFFFFFA
00000000000000 00000000000007 00000000000009 1 3FFFFFFFFFFFFFFFFFFFFFFFFFC1
00000000000123 00000000100000 00000000100000 0 00000000000048C0010000000000
00000000000000 FFFFFFFFFFFFFD 00000000000005 0 3FFFFFFFFFFFFFFFFFFFFFFFFFF1
00000000000055 0000000000ABCD 00000000000010 0 00000000000015400000000ABCD0
00000000000000 FFFFFFFFFFFFFD 00000000000005 1 000000000000000000000000000F
00000000000001 00000010000000 00000010000000 0 0000000000000140000000000000
00000000000000 7FFFFFFFFFFFFF 7FFFFFFFFFFFFF 0 3FFFFFFFFFFFFF00000000000001
00000000000001 00000010000000 00000010000000 1 3FFFFFFFFFFFFF40000000000000
00000000000000 7FFFFFFFFFFFFF 7FFFFFFFFFFFFF 1 00000000000000FFFFFFFFFFFFFF
00000000000002 FFFFFFFFFFFFFD 00000000000005 0 000000000000007FFFFFFFFFFFF1
00000000000000 7FFFFFFFFFFFFF 80000000000000 1 3FFFFFFFFFFFFF80000000000000
FFFFFFFFFFFFFF 00000000000000 00000000000000 0 3FFFFFFFFFFFFFC0000000000000
FFFFFFFFFFFFFF 00000000000002 00000000000003 1 3FFFFFFFFFFFFFBFFFFFFFFFFFFA
7FFFFFFFFFFFFF 7FFFFFFFFFFFFF 7FFFFFFFFFFFFF 1 20000000000000BFFFFFFFFFFFFF
80000000000000 00000000000001 00000000000001 0 2000000000000000000000000001
80000000000000 00000000000001 00000000000001 1 1FFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFF 7FFFFFFFFFFFFF 80000000000000 0 0000000000000040000000000000
00000000000001 80000000000000 80000000000000 1 0000000000000040000000000000
7FFFFFFFFFFFFF 00000000000001 00000000000001 0 1FFFFFFFFFFFFFC0000000000001
